// ==== Makefile ====
SRCS := all.f $(wildcard hw/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

obj_dir/tb_wb_periph: $(SRCS)
	verilator --binary --assert --timescale 1ns/100ps --top-module tb_wb_periph \
		-f all.f -o tb_wb_periph

run: obj_dir/tb_wb_periph
	@out="$$(./obj_dir/tb_wb_periph)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST PASSED"

clean:
	rm -rf obj_dir

// ==== all.f ====
hw/periph_pkg.sv
hw/wb_addr_decode.sv
hw/syscon_regs.sv
hw/gpio_regs.sv
hw/seg7_scan.sv
hw/wb_periph_top.sv
testbench/tb_wb_periph.sv

// ==== hw/gpio_regs.sv ====
`default_nettype none

module gpio_regs (
   input  wire                        clk,
   input  wire                        i_rst,
   input  wire periph_pkg::wb_req_t   i_wb_req,
   output periph_pkg::wb_rsp_t        o_wb_rsp,
   input  wire periph_pkg::wb_data_t  i_gpio_in,
   output periph_pkg::wb_data_t       o_gpio_out,
   output periph_pkg::wb_data_t       o_gpio_oe,
   output logic                       o_gpio_irq
);
   import periph_pkg::*;

   wb_data_t gpio_meta;
   wb_data_t gpio_sync;
   wb_data_t gpio_prev;
   wb_data_t gpio_ie;
   wb_data_t gpio_is;
   wb_data_t is_clr;
   wb_data_t rd_data;
   logic     ack;
   logic     req_new;
   logic     wr_en;
   reg_off_t offset;

   assign offset  = i_wb_req.adr[7:0];
   assign req_new = i_wb_req.cyc & i_wb_req.stb & ~ack;
   assign wr_en   = req_new & i_wb_req.we;

   // Two-flop synchronizer plus one stage for edge detect.
   always_ff @(posedge clk) begin
      gpio_meta <= i_gpio_in;
      gpio_sync <= gpio_meta;
      gpio_prev <= gpio_sync;
   end

   // Write one to clear in enabled bytes only
   assign is_clr = (wr_en && offset == GPIO_IS) ? wb_merge('0, i_wb_req.dat, i_wb_req.sel) : '0;

   // *************************************************************************
   // Registers
   // *************************************************************************
   always_ff @(posedge clk) begin
      if (i_rst) begin
         ack        <= 1'b0;
         o_gpio_out <= '0;
         o_gpio_oe  <= '0;
         gpio_ie    <= '0;
         gpio_is    <= '0;
      end else begin
         ack     <= req_new;
         // New change wins over a clear in the same cycle
         gpio_is <= (gpio_is & ~is_clr) | (gpio_sync ^ gpio_prev);
         if (wr_en) begin
            case (offset)
               GPIO_OUT: o_gpio_out <= wb_merge(o_gpio_out, i_wb_req.dat, i_wb_req.sel);
               GPIO_OE:  o_gpio_oe  <= wb_merge(o_gpio_oe, i_wb_req.dat, i_wb_req.sel);
               GPIO_IE:  gpio_ie    <= wb_merge(gpio_ie, i_wb_req.dat, i_wb_req.sel);
               default: ;
            endcase
         end
      end
   end

   always_ff @(posedge clk) begin
      if (req_new) begin
         case (offset)
            GPIO_IN:  rd_data <= gpio_sync;
            GPIO_OUT: rd_data <= o_gpio_out;
            GPIO_OE:  rd_data <= o_gpio_oe;
            GPIO_IE:  rd_data <= gpio_ie;
            GPIO_IS:  rd_data <= gpio_is;
            default:  rd_data <= '0;
         endcase
      end
   end

   assign o_wb_rsp   = '{dat: rd_data, ack: ack, err: 1'b0};
   assign o_gpio_irq = |(gpio_is & gpio_ie);

   a_irq_needs_enable: assert property (
      @(posedge clk) disable iff (i_rst)
      (gpio_ie == '0) |-> !o_gpio_irq
   );

endmodule

`default_nettype wire

// ==== hw/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

   // *************************************************************************
   // Bus widths
   // *************************************************************************
   localparam int WB_AW = 12;
   localparam int WB_DW = 32;

   typedef logic [WB_AW-1:0]   wb_adr_t;
   typedef logic [WB_DW-1:0]   wb_data_t;
   typedef logic [WB_DW/8-1:0] wb_sel_t;

   // *************************************************************************
   // Address map with the slave number in adr[11:8]
   // *************************************************************************
   typedef logic [3:0] slave_num_t;
   typedef logic [7:0] reg_off_t;

   localparam slave_num_t SLV_SYSCON = 4'd0;
   localparam slave_num_t SLV_GPIO   = 4'd1;

   typedef enum logic [1:0] {
      SEL_SYSCON,
      SEL_GPIO,
      SEL_NONE
   } slave_sel_t;

   localparam reg_off_t SYS_VERSION  = 8'h00;
   localparam reg_off_t SYS_SWIRQ    = 8'h04;
   localparam reg_off_t SYS_DISPLAY  = 8'h08;
   localparam reg_off_t SYS_MTIME    = 8'h0C;
   localparam reg_off_t SYS_MTIMECMP = 8'h10;

   localparam wb_data_t SYSCON_VERSION = 32'h0001_0203;

   localparam reg_off_t GPIO_IN  = 8'h00;
   localparam reg_off_t GPIO_OUT = 8'h04;
   localparam reg_off_t GPIO_OE  = 8'h08;
   localparam reg_off_t GPIO_IE  = 8'h0C;
   localparam reg_off_t GPIO_IS  = 8'h10;

   // Display segments are gfedcba and all active low
   localparam int SEG7_DIGITS     = 8;
   localparam int SEG7_DIV_CYCLES = 16;

   typedef logic [6:0]                     seg_t;
   typedef logic [SEG7_DIGITS-1:0]         an_t;
   typedef logic [$clog2(SEG7_DIGITS)-1:0] digit_t;

   typedef struct packed {
      wb_adr_t  adr;
      wb_data_t dat;
      wb_sel_t  sel;
      logic     we;
      logic     cyc;
      logic     stb;
   } wb_req_t;

   typedef struct packed {
      wb_data_t dat;
      logic     ack;
      logic     err;
   } wb_rsp_t;

   typedef struct packed {
      logic sw_irq4;
      logic sw_irq3;
      logic gpio_irq;
   } ext_irq_t;

   // Byte lanes of wdat replace those of cur where sel is set
   function automatic wb_data_t wb_merge(
      input wb_data_t cur,
      input wb_data_t wdat,
      input wb_sel_t  sel
   );
      wb_data_t res;
      res = cur;
      for (int i = 0; i < WB_DW / 8; i++) begin
         if (sel[i])
            res[i*8 +: 8] = wdat[i*8 +: 8];
      end
      return res;
   endfunction

endpackage

`default_nettype wire

// ==== hw/seg7_scan.sv ====
`default_nettype none

module seg7_scan #(
   parameter int div_cycles = periph_pkg::SEG7_DIV_CYCLES
) (
   input  wire                        clk,
   input  wire                        i_rst,
   input  wire periph_pkg::wb_data_t  i_value,
   output periph_pkg::an_t            o_an,
   output periph_pkg::seg_t           o_seg
);
   import periph_pkg::*;

   localparam int CNT_W = (div_cycles > 1) ? $clog2(div_cycles) : 1;

   logic [CNT_W-1:0] div_cnt;
   logic             step;
   logic             scanning;
   digit_t           digit;
   logic [3:0]       nibble;

   assign step = (div_cnt == CNT_W'(div_cycles - 1));

   // Digit index advances once per divider period
   always_ff @(posedge clk) begin
      if (i_rst) begin
         div_cnt  <= '0;
         digit    <= '0;
         scanning <= 1'b0;
      end else begin
         div_cnt <= step ? '0 : div_cnt + 1'b1;
         if (step) begin
            scanning <= 1'b1;
            if (scanning)
               digit <= digit + 1'b1;
         end
      end
   end

   assign nibble = i_value[{digit, 2'b00} +: 4];
   assign o_an   = scanning ? ~(an_t'(1) << digit) : '1;

   // Hex font in gfedcba where low lights the segment
   always_comb begin
      case (nibble)
         4'h0:    o_seg = ~7'h3F;
         4'h1:    o_seg = ~7'h06;
         4'h2:    o_seg = ~7'h5B;
         4'h3:    o_seg = ~7'h4F;
         4'h4:    o_seg = ~7'h66;
         4'h5:    o_seg = ~7'h6D;
         4'h6:    o_seg = ~7'h7D;
         4'h7:    o_seg = ~7'h07;
         4'h8:    o_seg = ~7'h7F;
         4'h9:    o_seg = ~7'h6F;
         4'hA:    o_seg = ~7'h77;
         4'hB:    o_seg = ~7'h7C;
         4'hC:    o_seg = ~7'h39;
         4'hD:    o_seg = ~7'h5E;
         4'hE:    o_seg = ~7'h79;
         default: o_seg = ~7'h71;
      endcase
   end

   a_one_anode: assert property (
      @(posedge clk) disable iff (i_rst)
      scanning |-> $onehot(~o_an)
   );

endmodule

`default_nettype wire

// ==== hw/syscon_regs.sv ====
`default_nettype none

module syscon_regs (
   input  wire                       clk,
   input  wire                       i_rst,
   input  wire periph_pkg::wb_req_t  i_wb_req,
   output periph_pkg::wb_rsp_t       o_wb_rsp,
   output periph_pkg::wb_data_t      o_display,
   output logic                      o_timer_irq,
   output logic                      o_sw_irq3,
   output logic                      o_sw_irq4
);
   import periph_pkg::*;

   wb_data_t mtime;
   wb_data_t mtimecmp;
   wb_data_t rd_data;
   logic     ack;
   logic     req_new;
   logic     wr_en;
   reg_off_t offset;

   assign offset  = i_wb_req.adr[7:0];
   assign req_new = i_wb_req.cyc & i_wb_req.stb & ~ack;
   assign wr_en   = req_new & i_wb_req.we;

   // *************************************************************************
   // Control registers and machine timer
   // *************************************************************************
   always_ff @(posedge clk) begin
      if (i_rst) begin
         ack         <= 1'b0;
         o_sw_irq3   <= 1'b0;
         o_sw_irq4   <= 1'b0;
         o_display   <= '0;
         mtime       <= '0;
         mtimecmp    <= '1;
         o_timer_irq <= 1'b0;
      end else begin
         ack         <= req_new;
         mtime       <= mtime + 1'b1;
         o_timer_irq <= (mtime >= mtimecmp);
         if (wr_en) begin
            case (offset)
               SYS_SWIRQ: begin
                  if (i_wb_req.sel[0]) begin
                     o_sw_irq3 <= i_wb_req.dat[0];
                     o_sw_irq4 <= i_wb_req.dat[1];
                  end
               end
               SYS_DISPLAY:  o_display <= wb_merge(o_display, i_wb_req.dat, i_wb_req.sel);
               SYS_MTIMECMP: mtimecmp  <= wb_merge(mtimecmp, i_wb_req.dat, i_wb_req.sel);
               default: ;
            endcase
         end
      end
   end

   // Read mux
   always_ff @(posedge clk) begin
      if (req_new) begin
         case (offset)
            SYS_VERSION:  rd_data <= SYSCON_VERSION;
            SYS_SWIRQ:    rd_data <= wb_data_t'({o_sw_irq4, o_sw_irq3});
            SYS_DISPLAY:  rd_data <= o_display;
            SYS_MTIME:    rd_data <= mtime;
            SYS_MTIMECMP: rd_data <= mtimecmp;
            default:      rd_data <= '0;
         endcase
      end
   end

   assign o_wb_rsp = '{dat: rd_data, ack: ack, err: 1'b0};

   a_ack_after_stb: assert property (
      @(posedge clk) disable iff (i_rst)
      ack |-> $past(i_wb_req.cyc & i_wb_req.stb)
   );

endmodule

`default_nettype wire

// ==== hw/wb_addr_decode.sv ====
`default_nettype none

module wb_addr_decode (
   input  wire                       clk,
   input  wire                       i_rst,
   input  wire periph_pkg::wb_req_t  i_wb_req,
   output periph_pkg::wb_req_t       o_sys_req,
   output periph_pkg::wb_req_t       o_gpio_req,
   input  wire periph_pkg::wb_rsp_t  i_sys_rsp,
   input  wire periph_pkg::wb_rsp_t  i_gpio_rsp,
   output periph_pkg::wb_rsp_t       o_wb_rsp
);
   import periph_pkg::*;

   slave_sel_t slv_sel;
   logic       err_q;

   always_comb begin
      case (slave_num_t'(i_wb_req.adr[11:8]))
         SLV_SYSCON: slv_sel = SEL_SYSCON;
         SLV_GPIO:   slv_sel = SEL_GPIO;
         default:    slv_sel = SEL_NONE;
      endcase
   end

   // Only the selected slave sees stb
   always_comb begin
      o_sys_req      = i_wb_req;
      o_sys_req.stb  = i_wb_req.stb & (slv_sel == SEL_SYSCON);
      o_gpio_req     = i_wb_req;
      o_gpio_req.stb = i_wb_req.stb & (slv_sel == SEL_GPIO);
   end

   // Single err pulse for an unmapped access
   always_ff @(posedge clk) begin
      if (i_rst) begin
         err_q <= 1'b0;
      end else begin
         err_q <= i_wb_req.cyc & i_wb_req.stb & (slv_sel == SEL_NONE) & ~err_q;
      end
   end

   always_comb begin
      case (slv_sel)
         SEL_SYSCON: o_wb_rsp = i_sys_rsp;
         SEL_GPIO:   o_wb_rsp = i_gpio_rsp;
         default:    o_wb_rsp = '{dat: '0, ack: 1'b0, err: err_q};
      endcase
   end

   a_ack_err_excl: assert property (
      @(posedge clk) disable iff (i_rst)
      !(o_wb_rsp.ack && o_wb_rsp.err)
   );

endmodule

`default_nettype wire

// ==== hw/wb_periph_top.sv ====
`default_nettype none

module wb_periph_top (
   input  wire                        clk,
   input  wire                        i_rst,
   input  wire periph_pkg::wb_req_t   i_wb_req,
   output periph_pkg::wb_rsp_t        o_wb_rsp,
   input  wire periph_pkg::wb_data_t  i_gpio_in,
   output periph_pkg::wb_data_t       o_gpio_out,
   output periph_pkg::wb_data_t       o_gpio_oe,
   output logic                       o_timer_irq,
   output periph_pkg::ext_irq_t       o_ext_irq,
   output periph_pkg::an_t            o_an,
   output periph_pkg::seg_t           o_seg
);
   import periph_pkg::*;

   wb_req_t  sys_req;
   wb_req_t  gpio_req;
   wb_rsp_t  sys_rsp;
   wb_rsp_t  gpio_rsp;
   wb_data_t display;
   logic     sw_irq3;
   logic     sw_irq4;
   logic     gpio_irq;

   wb_addr_decode wb_addr_decode_inst (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_wb_req   (i_wb_req),
      .o_sys_req  (sys_req),
      .o_gpio_req (gpio_req),
      .i_sys_rsp  (sys_rsp),
      .i_gpio_rsp (gpio_rsp),
      .o_wb_rsp   (o_wb_rsp)
   );

   syscon_regs syscon_regs_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_wb_req    (sys_req),
      .o_wb_rsp    (sys_rsp),
      .o_display   (display),
      .o_timer_irq (o_timer_irq),
      .o_sw_irq3   (sw_irq3),
      .o_sw_irq4   (sw_irq4)
   );

   gpio_regs gpio_regs_inst (
      .clk        (clk),
      .i_rst      (i_rst),
      .i_wb_req   (gpio_req),
      .o_wb_rsp   (gpio_rsp),
      .i_gpio_in  (i_gpio_in),
      .o_gpio_out (o_gpio_out),
      .o_gpio_oe  (o_gpio_oe),
      .o_gpio_irq (gpio_irq)
   );

   seg7_scan #(
      .div_cycles (SEG7_DIV_CYCLES)
   ) seg7_scan_inst (
      .clk     (clk),
      .i_rst   (i_rst),
      .i_value (display),
      .o_an    (o_an),
      .o_seg   (o_seg)
   );

   // External interrupt lines towards the PIC
   assign o_ext_irq = '{sw_irq4: sw_irq4, sw_irq3: sw_irq3, gpio_irq: gpio_irq};

endmodule

`default_nettype wire

// ==== testbench/tb_wb_periph.sv ====
`default_nettype none

module tb_wb_periph;
   timeunit 1ns;
   timeprecision 100ps;

   import periph_pkg::*;

   localparam int BUS_TIMEOUT = 20;

   logic     clk = 1'b0;
   logic     i_rst;
   wb_req_t  wb_req;
   wb_rsp_t  wb_rsp;
   wb_data_t gpio_in;
   wb_data_t gpio_out;
   wb_data_t gpio_oe;
   logic     timer_irq;
   ext_irq_t ext_irq;
   an_t      an;
   seg_t     seg;

   int       errors = 0;
   int       timeouts = 0;
   logic     scan_on = 1'b0;
   logic     ie_off = 1'b0;
   wb_data_t disp_exp = '0;

   always #2 clk = ~clk;

   wb_periph_top wb_periph_top_inst (
      .clk         (clk),
      .i_rst       (i_rst),
      .i_wb_req    (wb_req),
      .o_wb_rsp    (wb_rsp),
      .i_gpio_in   (gpio_in),
      .o_gpio_out  (gpio_out),
      .o_gpio_oe   (gpio_oe),
      .o_timer_irq (timer_irq),
      .o_ext_irq   (ext_irq),
      .o_an        (an),
      .o_seg       (seg)
   );

   // Active-low gfedcba patterns for hex digits
   function automatic seg_t hex_font(input logic [3:0] nib);
      case (nib)
         4'h0:    return 7'h40;
         4'h1:    return 7'h79;
         4'h2:    return 7'h24;
         4'h3:    return 7'h30;
         4'h4:    return 7'h19;
         4'h5:    return 7'h12;
         4'h6:    return 7'h02;
         4'h7:    return 7'h78;
         4'h8:    return 7'h00;
         4'h9:    return 7'h10;
         4'hA:    return 7'h08;
         4'hB:    return 7'h03;
         4'hC:    return 7'h46;
         4'hD:    return 7'h21;
         4'hE:    return 7'h06;
         default: return 7'h0E;
      endcase
   endfunction

   // Segments for the digit whose anode is low
   function automatic seg_t expected_seg(input wb_data_t val, input an_t a);
      an_t        a_sh;
      wb_data_t   v_sh;
      logic [3:0] nib;
      nib = 4'h0;
      for (int i = 0; i < SEG7_DIGITS; i++) begin
         a_sh = a >> i;
         v_sh = val >> (4 * i);
         if (!a_sh[0])
            nib = v_sh[3:0];
      end
      return hex_font(nib);
   endfunction

   function automatic wb_adr_t sys_adr(input reg_off_t off);
      return {SLV_SYSCON, off};
   endfunction

   function automatic wb_adr_t gpio_adr(input reg_off_t off);
      return {SLV_GPIO, off};
   endfunction

   // *************************************************************************
   // Checking
   // *************************************************************************
   a_scan_one_low: assert property (@(posedge clk) disable iff (i_rst)
      scan_on |-> $onehot(~an))
   else begin
      errors++;
      $display("[ERROR] o_an = %h, not exactly one low bit", an);
   end

   a_scan_seg: assert property (@(posedge clk) disable iff (i_rst)
      scan_on |-> (seg == expected_seg(disp_exp, an)))
   else begin
      errors++;
      $display("[ERROR] o_seg = %h, expected %h", seg, expected_seg(disp_exp, an));
   end

   a_gpio_irq_off: assert property (@(posedge clk) disable iff (i_rst)
      ie_off |-> !ext_irq.gpio_irq)
   else begin
      errors++;
      $display("[ERROR] o_ext_irq.gpio_irq = %h, expected %h", ext_irq.gpio_irq, 1'b0);
   end

   task automatic check_value(input string name, input wb_data_t got, input wb_data_t exp);
      assert (got == exp)
      else begin
         errors++;
         $display("[ERROR] %s = %h, expected %h", name, got, exp);
      end
   endtask

   task automatic finish_run();
      $display("Run complete: %0d errors, %0d timeouts", errors, timeouts);
      if (errors == 0 && timeouts == 0)
         $display("TEST PASSED");
      else
         $display("TEST FAILED");
      $finish;
   endtask

   task automatic stop_on_timeout(input string what);
      $display("Timed out waiting for %s", what);
      timeouts++;
      finish_run();
   endtask

   // One transfer, entered and left on a falling edge
   task automatic bus_xfer(input wb_adr_t adr, input wb_data_t dat, input wb_sel_t sel,
                           input logic we, output wb_data_t rdat, output logic ack_seen,
                           output logic err_seen);
      int cnt;
      cnt = 0;
      ack_seen = 1'b0;
      err_seen = 1'b0;
      rdat = '0;
      wb_req = '{adr: adr, dat: dat, sel: sel, we: we, cyc: 1'b1, stb: 1'b1};
      while (!ack_seen && !err_seen) begin
         @(negedge clk);
         ack_seen = wb_rsp.ack;
         err_seen = wb_rsp.err;
         rdat = wb_rsp.dat;
         cnt++;
         if (cnt > BUS_TIMEOUT && !ack_seen && !err_seen)
            stop_on_timeout("bus acknowledge");
      end
      wb_req.stb = 1'b0;
      wb_req.cyc = 1'b0;
      @(negedge clk);
   endtask

   task automatic reg_write(input wb_adr_t adr, input wb_data_t dat, input wb_sel_t sel);
      wb_data_t rdat;
      logic     ack;
      logic     err;
      bus_xfer(adr, dat, sel, 1'b1, rdat, ack, err);
      check_value("o_wb_rsp.err", 32'(err), 32'd0);
   endtask

   task automatic reg_read(input wb_adr_t adr, output wb_data_t rdat);
      logic ack;
      logic err;
      bus_xfer(adr, '0, 4'hF, 1'b0, rdat, ack, err);
      check_value("o_wb_rsp.err", 32'(err), 32'd0);
   endtask

   // *************************************************************************
   // Stimulus
   // *************************************************************************
   initial begin
      wb_data_t rdat;
      wb_data_t val;
      wb_data_t prev;
      wb_data_t out_exp;
      wb_data_t mt;
      wb_data_t cmp;
      logic     ack;
      logic     err;
      int       bit_idx;
      int       cnt;
      an_t      seen;

      void'($urandom(32'heba));
      wb_req = '0;
      gpio_in = '0;
      i_rst = 1'b1;
      repeat (4) @(negedge clk);
      i_rst = 1'b0;
      @(negedge clk);

      check_value("o_timer_irq", 32'(timer_irq), 32'd0);
      check_value("o_ext_irq", 32'(ext_irq), 32'd0);
      check_value("o_gpio_oe", gpio_oe, 32'd0);
      check_value("o_gpio_out", gpio_out, 32'd0);
      reg_read(sys_adr(SYS_VERSION), rdat);
      check_value("SYS_VERSION", rdat, 32'h0001_0203);
      reg_read(sys_adr(SYS_MTIMECMP), rdat);
      check_value("SYS_MTIMECMP", rdat, 32'hFFFF_FFFF);

      // GPIO output and enable registers
      for (int i = 0; i < 4; i++) begin
         val = $urandom;
         reg_write(gpio_adr(GPIO_OUT), val, 4'hF);
         prev = val;
         check_value("o_gpio_out", gpio_out, val);
         reg_read(gpio_adr(GPIO_OUT), rdat);
         check_value("GPIO_OUT", rdat, val);
         val = $urandom;
         reg_write(gpio_adr(GPIO_OE), val, 4'hF);
         check_value("o_gpio_oe", gpio_oe, val);
         reg_read(gpio_adr(GPIO_OE), rdat);
         check_value("GPIO_OE", rdat, val);
      end
      val = $urandom;
      reg_write(gpio_adr(GPIO_OUT), val, 4'b0100);
      out_exp = {prev[31:24], val[23:16], prev[15:0]};
      check_value("o_gpio_out", gpio_out, out_exp);

      // Change interrupt with one enabled bit
      reg_write(gpio_adr(GPIO_IS), '1, 4'hF);
      bit_idx = $urandom_range(31, 0);
      reg_write(gpio_adr(GPIO_IE), wb_data_t'(1) << bit_idx, 4'hF);
      gpio_in = gpio_in ^ (wb_data_t'(1) << bit_idx);
      cnt = 0;
      while (!ext_irq.gpio_irq) begin
         @(negedge clk);
         cnt++;
         if (cnt > 10 && !ext_irq.gpio_irq)
            stop_on_timeout("GPIO change interrupt");
      end
      reg_read(gpio_adr(GPIO_IS), rdat);
      check_value("GPIO_IS", rdat, wb_data_t'(1) << bit_idx);
      reg_read(gpio_adr(GPIO_IN), rdat);
      check_value("GPIO_IN", rdat, gpio_in);
      reg_write(gpio_adr(GPIO_IS), wb_data_t'(1) << bit_idx, 4'hF);
      check_value("o_ext_irq.gpio_irq", 32'(ext_irq.gpio_irq), 32'd0);

      // Pending status with the enable cleared
      reg_write(gpio_adr(GPIO_IE), '0, 4'hF);
      ie_off = 1'b1;
      bit_idx = $urandom_range(31, 0);
      gpio_in = gpio_in ^ (wb_data_t'(1) << bit_idx);
      repeat (10) @(negedge clk);
      reg_read(gpio_adr(GPIO_IS), rdat);
      check_value("GPIO_IS", rdat, wb_data_t'(1) << bit_idx);
      reg_write(gpio_adr(GPIO_IS), '1, 4'hF);

      // Machine timer
      reg_read(sys_adr(SYS_MTIME), mt);
      cmp = mt + 32'd200;
      reg_write(sys_adr(SYS_MTIMECMP), cmp, 4'hF);
      check_value("o_timer_irq", 32'(timer_irq), 32'd0);
      cnt = 0;
      while (!timer_irq) begin
         @(negedge clk);
         cnt++;
         if (cnt > 400 && !timer_irq)
            stop_on_timeout("timer interrupt");
      end
      reg_read(sys_adr(SYS_MTIME), mt);
      assert (mt >= cmp)
      else begin
         errors++;
         $display("[ERROR] SYS_MTIME = %h, below mtimecmp %h", mt, cmp);
      end

      reg_write(sys_adr(SYS_SWIRQ), 32'd1, 4'hF);
      check_value("o_ext_irq.sw_irq3", 32'(ext_irq.sw_irq3), 32'd1);
      check_value("o_ext_irq.sw_irq4", 32'(ext_irq.sw_irq4), 32'd0);
      reg_write(sys_adr(SYS_SWIRQ), 32'd2, 4'hF);
      check_value("o_ext_irq.sw_irq3", 32'(ext_irq.sw_irq3), 32'd0);
      check_value("o_ext_irq.sw_irq4", 32'(ext_irq.sw_irq4), 32'd1);

      // Slave 5 is not mapped
      bus_xfer({4'd5, GPIO_OUT}, $urandom, 4'hF, 1'b1, rdat, ack, err);
      check_value("o_wb_rsp.err", 32'(err), 32'd1);
      check_value("o_wb_rsp.ack", 32'(ack), 32'd0);
      bus_xfer({4'd5, SYS_MTIMECMP}, '0, 4'hF, 1'b0, rdat, ack, err);
      check_value("o_wb_rsp.err", 32'(err), 32'd1);
      check_value("o_wb_rsp.ack", 32'(ack), 32'd0);
      check_value("o_wb_rsp.dat", rdat, 32'd0);
      reg_read(gpio_adr(GPIO_OUT), rdat);
      check_value("GPIO_OUT", rdat, out_exp);
      reg_read(sys_adr(SYS_MTIMECMP), rdat);
      check_value("SYS_MTIMECMP", rdat, cmp);

      // Display scan over all eight digits
      val = $urandom;
      disp_exp = val;
      reg_write(sys_adr(SYS_DISPLAY), val, 4'hF);
      scan_on = 1'b1;
      seen = '0;
      cnt = 0;
      while (seen != '1) begin
         @(negedge clk);
         seen = seen | ~an;
         cnt++;
         if (cnt > 2 * SEG7_DIGITS * SEG7_DIV_CYCLES && seen != '1)
            stop_on_timeout("all display digits");
      end
      reg_read(sys_adr(SYS_DISPLAY), rdat);
      check_value("SYS_DISPLAY", rdat, val);

      finish_run();
   end

endmodule

`default_nettype wire
